//--- flist.f
hw/memCtrlPkg.sv
hw/memReqDecode.sv
hw/memByteSequencer.sv
hw/memResultAssembler.sv
hw/memCtrl.sv
tests/memCtrl_asserts.sv
tests/memCtrlTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= memCtrlTb
RTL_TOP   ?= memCtrl
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST RESULT: PASS
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
RTL_FILES ?= hw/memCtrlPkg.sv hw/memReqDecode.sv hw/memByteSequencer.sv \
             hw/memResultAssembler.sv hw/memCtrl.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timescale 1ns/100ps --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/memCtrlTb.sv
`timescale 1ns/100ps
`default_nettype none

module memCtrlTb;
    import memCtrlPkg::*;

    localparam int TIMEOUT = 50;

    logic              clk;
    logic              rst;
    logic              rdy;
    logic              fetchReq;
    logic [ADDR_W-1:0] fetchAddr;
    logic              fetchDone;
    logic [DATA_W-1:0] fetchInst;
    logic              dataReq;
    dataReq_t          dataInfo;
    logic              dataDone;
    logic [DATA_W-1:0] dataRdata;
    memBus_t           memBus;
    logic [MEM_W-1:0]  memRdata = '0;
    memOwner_e         busyOwner;

    // RAM behind the DUT and the expected contents
    logic [MEM_W-1:0]  ram [256];
    logic [MEM_W-1:0]  refMem [256];

    memCtrl memCtrl_i (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (rdy),
        .i_fetchReq    (fetchReq),
        .i_fetchAddr   (fetchAddr),
        .o_fetchDone   (fetchDone),
        .o_fetchInst   (fetchInst),
        .i_dataReq     (dataReq),
        .i_dataReqInfo (dataInfo),
        .o_dataDone    (dataDone),
        .o_dataRdata   (dataRdata),
        .o_memBus      (memBus),
        .i_memRdata    (memRdata),
        .o_busyOwner   (busyOwner)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // synchronous read that holds while the controller is frozen
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                ram[i] <= refMem[i];
            end
        end else if (rdy) begin
            if (memBus.we) begin
                ram[memBus.addr[7:0]] <= memBus.wdata;
            end
            memRdata <= ram[memBus.addr[7:0]];
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
        if (exp !== act) begin
            failRun($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic checkOwner(input string name, input memOwner_e exp, input memOwner_e act);
        if (exp !== act) begin
            failRun($sformatf("error %s: expected %s, actual %s", name, exp.name(), act.name()));
        end
    endtask

    // little-endian word zero-extended above nBytes
    function automatic logic [DATA_W-1:0] expectWord(input logic [ADDR_W-1:0] addr,
                                                     input int nBytes);
        logic [DATA_W-1:0] w;
        w = '0;
        for (int k = 0; k < nBytes; k++) begin
            w[k*MEM_W +: MEM_W] = refMem[8'(addr + ADDR_W'(k))];
        end
        return w;
    endfunction

    // counts falling edges from the request cycle and can freeze the DUT
    task automatic waitDone(input string name, input logic isFetch, input memOwner_e expOwner,
                            input logic checkFirst, input int stallLen, output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (stallLen > 0 && cycles == 2) begin
                rdy = 1'b0;
            end
            if (stallLen > 0 && cycles == 2 + stallLen) begin
                rdy = 1'b1;
            end
            if (checkFirst && cycles == 1) begin
                checkOwner({name, " owner"}, expOwner, busyOwner);
            end
            seen = isFetch ? fetchDone : dataDone;
        end
        if (!seen) begin
            failRun($sformatf("%s: no done pulse within %0d cycles", name, TIMEOUT));
        end else begin
            checkOwner({name, " owner at done"}, expOwner, busyOwner);
        end
    endtask

    task automatic dataTxn(input string name, input logic store, input memLen_e len,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                           input int stallLen, output logic [DATA_W-1:0] rdata);
        int cycles;
        @(negedge clk);
        dataInfo = '{isStore: store, len: len, addr: addr, wdata: wdata};
        dataReq  = 1'b1;
        waitDone(name, 1'b0, OWN_DATA, 1'b1, stallLen, cycles);
        dataReq = 1'b0;
        rdata   = dataRdata;
        checkWord({name, " latency"}, DATA_W'(int'(len) + 2 + stallLen), DATA_W'(cycles));
    endtask

    task automatic testReset;
        checkOwner("reset", OWN_IDLE, busyOwner);
        if (fetchDone || dataDone) begin
            failRun($sformatf("error reset: expected fetch done 0 and data done 0, actual %b and %b",
                              fetchDone, dataDone));
        end
    endtask

    task automatic testFetch(input string name, input int stallLen);
        logic [ADDR_W-1:0] addr;
        int                cycles;
        addr = $urandom;
        @(negedge clk);
        fetchAddr = addr;
        fetchReq  = 1'b1;
        waitDone(name, 1'b1, OWN_FETCH, 1'b1, stallLen, cycles);
        fetchReq = 1'b0;
        checkWord(name, expectWord(addr, 4), fetchInst);
        checkWord({name, " latency"}, DATA_W'(6 + stallLen), DATA_W'(cycles));
    endtask

    task automatic testLoad(input memLen_e len);
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] rdata;
        string             name;
        name = $sformatf("load %s", len.name());
        addr = $urandom;
        dataTxn(name, 1'b0, len, addr, '0, 0, rdata);
        checkWord(name, expectWord(addr, int'(len)), rdata);
    endtask

    task automatic testStore(input string name, input memLen_e len, input int stallLen);
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] mask;
        logic [DATA_W-1:0] expected;
        logic [DATA_W-1:0] rdata;
        addr = $urandom;
        wdata = $urandom;
        mask = '0;
        for (int k = 0; k < int'(len); k++) begin
            mask[k*MEM_W +: MEM_W] = '1;
        end
        // only the lower bytes may change
        expected = (expectWord(addr, 4) & ~mask) | (wdata & mask);
        for (int k = 0; k < int'(len); k++) begin
            refMem[8'(addr + ADDR_W'(k))] = wdata[k*MEM_W +: MEM_W];
        end
        dataTxn(name, 1'b1, len, addr, wdata, stallLen, rdata);
        dataTxn({name, " readback"}, 1'b0, LEN_WORD, addr, '0, 0, rdata);
        checkWord(name, expected, rdata);
    endtask

    task automatic testArbitration;
        logic [ADDR_W-1:0] fAddr;
        logic [ADDR_W-1:0] dAddr;
        int                cycles;
        fAddr = $urandom;
        dAddr = $urandom;
        @(negedge clk);
        fetchAddr = fAddr;
        fetchReq  = 1'b1;
        dataInfo  = '{isStore: 1'b0, len: LEN_WORD, addr: dAddr, wdata: '0};
        dataReq   = 1'b1;
        waitDone("arbitration data", 1'b0, OWN_DATA, 1'b1, 0, cycles);
        dataReq = 1'b0;
        checkWord("arbitration data", expectWord(dAddr, 4), dataRdata);
        // fetch level stays up and is taken once decode is idle again
        waitDone("arbitration fetch", 1'b1, OWN_FETCH, 1'b0, 0, cycles);
        fetchReq = 1'b0;
        checkWord("arbitration fetch", expectWord(fAddr, 4), fetchInst);
    endtask

    initial begin
        void'($urandom(96));
        rst       = 1'b1;
        rdy       = 1'b1;
        fetchReq  = 1'b0;
        fetchAddr = '0;
        dataReq   = 1'b0;
        dataInfo  = '0;
        for (int i = 0; i < 256; i++) begin
            refMem[i] = 8'($urandom);
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;

        testReset();
        testFetch("fetch", 0);
        testLoad(LEN_BYTE);
        testLoad(LEN_HALF);
        testLoad(LEN_WORD);
        testStore("store byte", LEN_BYTE, 0);
        testStore("store half", LEN_HALF, 0);
        testStore("store word", LEN_WORD, 0);
        testArbitration();
        testFetch("stalled fetch", 1 + int'($urandom % 4));
        testStore("stalled store", LEN_WORD, 1 + int'($urandom % 4));

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/memCtrl_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module memCtrl_asserts (
    input logic                   clk,
    input logic                   rst,
    input logic                   i_rdy,
    input memCtrlPkg::memBus_t    i_memBus,
    input logic                   i_fetchDone,
    input logic                   i_dataDone,
    input memCtrlPkg::memOwner_e  i_busyOwner
);
    import memCtrlPkg::*;

    // RAM is never written while frozen
    weHeldInStall: assert property (@(posedge clk) disable iff (rst)
        !i_rdy |-> !i_memBus.we)
        else $error("write enable high while i_rdy is low");

    oneDoneOnly: assert property (@(posedge clk) disable iff (rst)
        !(i_fetchDone && i_dataDone))
        else $error("fetch done and data done high together");

    // decode drops back to idle right after a done
    idleAfterDone: assert property (@(posedge clk) disable iff (rst)
        (i_rdy && (i_fetchDone || i_dataDone)) |=> (i_busyOwner == OWN_IDLE))
        else $error("owner not idle in the cycle after done");

endmodule

bind memCtrl memCtrl_asserts memCtrl_asserts_i (
    .clk         (clk),
    .rst         (rst),
    .i_rdy       (i_rdy),
    .i_memBus    (o_memBus),
    .i_fetchDone (o_fetchDone),
    .i_dataDone  (o_dataDone),
    .i_busyOwner (o_busyOwner)
);

`default_nettype wire

//--- hw/memCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module memCtrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_rdy,

    // fetch port
    input  logic                           i_fetchReq,
    input  logic [memCtrlPkg::ADDR_W-1:0]  i_fetchAddr,
    output logic                           o_fetchDone,
    output logic [memCtrlPkg::DATA_W-1:0]  o_fetchInst,

    // data port
    input  logic                           i_dataReq,
    input  memCtrlPkg::dataReq_t           i_dataReqInfo,
    output logic                           o_dataDone,
    output logic [memCtrlPkg::DATA_W-1:0]  o_dataRdata,

    // RAM
    output memCtrlPkg::memBus_t            o_memBus,
    input  logic [memCtrlPkg::MEM_W-1:0]   i_memRdata,

    output memCtrlPkg::memOwner_e          o_busyOwner
);
    import memCtrlPkg::*;

    logic     start;
    logic     txnDone;
    memReq_t  req;
    laneEvt_t lane;

    memReqDecode memReqDecode_i (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (i_rdy),
        .i_fetchReq    (i_fetchReq),
        .i_fetchAddr   (i_fetchAddr),
        .i_dataReq     (i_dataReq),
        .i_dataReqInfo (i_dataReqInfo),
        .i_txnDone     (txnDone),
        .o_start       (start),
        .o_req         (req),
        .o_busyOwner   (o_busyOwner)
    );

    memByteSequencer memByteSequencer_i (
        .clk      (clk),
        .rst      (rst),
        .i_rdy    (i_rdy),
        .i_start  (start),
        .i_req    (req),
        .o_memBus (o_memBus),
        .o_lane   (lane)
    );

    // op stays latched in decode until done
    memResultAssembler memResultAssembler_i (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (i_rdy),
        .i_lane      (lane),
        .i_op        (req.op),
        .i_memRdata  (i_memRdata),
        .o_txnDone   (txnDone),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata)
    );

endmodule

`default_nettype wire

//--- hw/memResultAssembler.sv
`timescale 1ns/100ps
`default_nettype none

module memResultAssembler (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_rdy,

    // byte steps from the sequencer
    input  memCtrlPkg::laneEvt_t           i_lane,
    input  memCtrlPkg::memOp_e             i_op,
    input  logic [memCtrlPkg::MEM_W-1:0]   i_memRdata,

    // back to decode
    output logic                           o_txnDone,

    // fetch port results
    output logic                           o_fetchDone,
    output logic [memCtrlPkg::DATA_W-1:0]  o_fetchInst,

    // data port results
    output logic                           o_dataDone,
    output logic [memCtrlPkg::DATA_W-1:0]  o_dataRdata
);
    import memCtrlPkg::*;

    logic [DATA_W-1:0] word;
    logic              finish;
    logic              isFetch;

    assign finish  = i_lane.valid && i_lane.last;
    assign isFetch = (i_op == OP_FETCH);

    // little-endian assembly, byte 0 zero-fills the upper lanes
    always_ff @(posedge clk) begin
        if (i_rdy && i_lane.valid && i_lane.isRead) begin
            if (i_lane.idx == '0) begin
                word <= DATA_W'(i_memRdata);
            end else begin
                word[i_lane.idx*MEM_W +: MEM_W] <= i_memRdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_txnDone   <= 1'b0;
            o_fetchDone <= 1'b0;
            o_dataDone  <= 1'b0;
        end else if (i_rdy) begin
            o_txnDone   <= finish;
            o_fetchDone <= finish && isFetch;
            // loads and stores both answer on the data port
            o_dataDone  <= finish && !isFetch;
        end
    end

    assign o_fetchInst = word;
    assign o_dataRdata = word;

endmodule

`default_nettype wire

//--- hw/memByteSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module memByteSequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_rdy,

    // from decode
    input  logic                  i_start,
    input  memCtrlPkg::memReq_t   i_req,

    // RAM drive
    output memCtrlPkg::memBus_t   o_memBus,

    // to the result stage
    output memCtrlPkg::laneEvt_t  o_lane
);
    import memCtrlPkg::*;

    logic [BYTES_W-1:0] idx;
    logic [BYTES_W-1:0] lastIdx;
    logic               running;
    logic               active;
    logic               isStore;
    logic               atLast;

    // start covers byte 0, running covers the rest
    assign active  = i_start || running;
    assign isStore = (i_req.op == OP_STORE);

    // length encoding is the byte count
    assign lastIdx = BYTES_W'(i_req.len) - BYTES_W'(1);
    assign atLast  = (idx == lastIdx);

    always_comb begin
        o_memBus.addr  = i_req.addr + ADDR_W'(idx);
        o_memBus.wdata = i_req.wdata[idx*MEM_W +: MEM_W];
        // no write while frozen
        o_memBus.we    = active && isStore && i_rdy;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idx     <= '0;
            running <= 1'b0;
        end else if (i_rdy && active) begin
            if (atLast) begin
                idx     <= '0;
                running <= 1'b0;
            end else begin
                idx     <= idx + BYTES_W'(1);
                running <= 1'b1;
            end
        end
    end

    // lane event lines up with the synchronous RAM read
    always_ff @(posedge clk) begin
        if (rst) begin
            o_lane <= '0;
        end else if (i_rdy) begin
            if (active) begin
                o_lane.valid  <= 1'b1;
                o_lane.isRead <= !isStore;
                o_lane.idx    <= idx;
                o_lane.last   <= atLast;
            end else begin
                o_lane.valid  <= 1'b0;
                o_lane.isRead <= 1'b0;
                o_lane.idx    <= '0;
                o_lane.last   <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/memReqDecode.sv
`timescale 1ns/100ps
`default_nettype none

module memReqDecode (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_rdy,

    // fetch port
    input  logic                           i_fetchReq,
    input  logic [memCtrlPkg::ADDR_W-1:0]  i_fetchAddr,

    // data port
    input  logic                           i_dataReq,
    input  memCtrlPkg::dataReq_t           i_dataReqInfo,

    // from the result stage
    input  logic                           i_txnDone,

    // to the sequencer
    output logic                           o_start,
    output memCtrlPkg::memReq_t            o_req,

    output memCtrlPkg::memOwner_e          o_busyOwner
);
    import memCtrlPkg::*;

    typedef enum logic {
        DEC_IDLE = 1'b0,
        DEC_BUSY = 1'b1
    } decState_e;

    decState_e state;
    memReq_t   nextReq;
    logic      anyReq;

    assign anyReq = i_dataReq || i_fetchReq;

    // data port has priority
    always_comb begin
        if (i_dataReq) begin
            nextReq.op    = i_dataReqInfo.isStore ? OP_STORE : OP_LOAD;
            nextReq.len   = i_dataReqInfo.len;
            nextReq.addr  = i_dataReqInfo.addr;
            nextReq.wdata = i_dataReqInfo.wdata;
        end else begin
            nextReq.op    = OP_FETCH;
            nextReq.len   = LEN_WORD;
            nextReq.addr  = i_fetchAddr;
            nextReq.wdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= DEC_IDLE;
            o_start <= 1'b0;
        end else if (i_rdy) begin
            o_start <= 1'b0;
            case (state)
                DEC_IDLE: begin
                    if (anyReq) begin
                        state   <= DEC_BUSY;
                        o_start <= 1'b1;
                    end
                end
                DEC_BUSY: begin
                    // done cycle itself is never an accept
                    if (i_txnDone) begin
                        state <= DEC_IDLE;
                    end
                end
                default: begin
                    state <= DEC_IDLE;
                end
            endcase
        end
    end

    // request payload, only loaded while idle
    always_ff @(posedge clk) begin
        if (i_rdy && state == DEC_IDLE && anyReq) begin
            o_req <= nextReq;
        end
    end

    always_comb begin
        if (state == DEC_BUSY) begin
            o_busyOwner = (o_req.op == OP_FETCH) ? OWN_FETCH : OWN_DATA;
        end else begin
            o_busyOwner = OWN_IDLE;
        end
    end

endmodule

`default_nettype wire

//--- hw/memCtrlPkg.sv
`default_nettype none

package memCtrlPkg;

    // bus widths
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int MEM_W   = 8;
    localparam int BYTES_W = 3;

    // value is the byte count
    typedef enum logic [2:0] {
        LEN_BYTE = 3'd1,
        LEN_HALF = 3'd2,
        LEN_WORD = 3'd4
    } memLen_e;

    typedef enum logic [1:0] {
        OP_FETCH = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } memOp_e;

    // current holder of the RAM
    typedef enum logic [1:0] {
        OWN_IDLE  = 2'd0,
        OWN_DATA  = 2'd1,
        OWN_FETCH = 2'd2
    } memOwner_e;

    // data port request as presented by the core
    typedef struct packed {
        logic              isStore;
        memLen_e           len;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } dataReq_t;

    // transaction held for the whole access
    typedef struct packed {
        memOp_e            op;
        memLen_e           len;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } memReq_t;

    // byte-wide RAM drive
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [MEM_W-1:0]  wdata;
    } memBus_t;

    // one byte step, trails the bus by a cycle
    typedef struct packed {
        logic               valid;
        logic               isRead;
        logic [BYTES_W-1:0] idx;
        logic               last;
    } laneEvt_t;

endpackage

`default_nettype wire
